// ==== design/bus_pkg.sv ====
package bus_pkg;

    // ------------------------------------------------------------------
    // Basic widths
    // ------------------------------------------------------------------
    typedef logic [31:0] xlen_t;    // Data and address word
    typedef logic [3:0]  be_t;      // One enable per byte lane

    // ------------------------------------------------------------------
    // Core side (req/gnt/rvalid)
    // ------------------------------------------------------------------

    // Data request as the core presents it
    typedef struct packed {
        logic  we;      // 1 = write, 0 = read
        be_t   be;      // Byte lanes touched by a write
        xlen_t addr;    // Byte address
        xlen_t wdata;   // Write payload
    } mem_req_t;

    // Response back to the core, valid with rvalid only
    typedef struct packed {
        xlen_t rdata;
        logic  err;     // Tied low in this fabric
    } mem_rsp_t;

    // ------------------------------------------------------------------
    // ICB command channel
    // ------------------------------------------------------------------
    typedef struct packed {
        logic  read;    // Inverse of core write flag
        xlen_t addr;
        xlen_t wdata;
        be_t   wmask;   // Same as core byte enables
    } icb_cmd_t;

endpackage

// ==== design/map_pkg.sv ====
package map_pkg;

    // ------------------------------------------------------------------
    // Address map of the data port
    // ------------------------------------------------------------------

    // TCM window, size set by tcm_awidth at the top level
    localparam logic [31:0] TCM_BASE    = 32'h8000_0000;

    // Peripheral data window, 256 MB
    localparam logic [31:0] PERIPH_BASE = 32'h1000_0000;
    localparam logic [31:0] PERIPH_MASK = 32'h0fff_ffff;   // Offset bits inside window

    // Result of the address decode
    typedef enum logic [1:0] {
        NONE   = 2'd0,  // Unmapped, never granted
        TCM    = 2'd1,
        PERIPH = 2'd2
    } region_e;

    // Spare encoding 2'd3 left unused

endpackage

// ==== design/tcm_ram.sv ====
`timescale 1ns/100ps

module tcm_ram #(
    parameter int tcm_awidth = 12             // Byte address bits
) (
    input  logic                   clk,
    input  logic                   ena_i,      // Port A enable, fetch side
    input  logic                   enb_i,      // Port B enable, data side
    input  logic [tcm_awidth-3:0]  addra_i,    // Word index
    input  logic [tcm_awidth-3:0]  addrb_i,    // Word index
    input  bus_pkg::be_t           web_i,      // Byte write enables, port B
    input  bus_pkg::xlen_t         dinb_i,
    output bus_pkg::xlen_t         douta_o,
    output bus_pkg::xlen_t         doutb_o
);
    import bus_pkg::*;

    localparam int depth    = 2 ** (tcm_awidth - 2);
    localparam int nb_lanes = $bits(be_t);
    localparam int lane_w   = $bits(xlen_t) / nb_lanes;   // 8

    xlen_t mem [depth];

    // Memory starts out all zero
    initial begin
        for (int i = 0; i < depth; i++) begin
            mem[i] = '0;
        end
    end

    // ------------------------------------------------------------------
    // Port A, read only
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (ena_i) begin
            douta_o <= mem[addra_i];
        end
    end

    // ------------------------------------------------------------------
    // Port B, read with byte-masked write
    // ------------------------------------------------------------------
    always @(posedge clk) begin
        if (enb_i) begin
            doutb_o <= mem[addrb_i];    // Old word on read-during-write
            for (int i = 0; i < nb_lanes; i++) begin
                if (web_i[i]) begin
                    mem[addrb_i][i*lane_w +: lane_w] <= dinb_i[i*lane_w +: lane_w];
                end
            end
        end
    end

endmodule

// ==== design/tcm_port.sv ====
`timescale 1ns/100ps

module tcm_port #(
    parameter int tcm_awidth = 12
) (
    input  logic              clk,
    input  logic              rst_n,
    // Instruction bus, straight from the core
    input  logic              instr_req_i,
    input  bus_pkg::xlen_t    instr_addr_i,
    output logic              instr_gnt_o,
    output logic              instr_rvalid_o,
    output bus_pkg::xlen_t    instr_rdata_o,
    // Data bus, already decoded by the mux
    input  logic              data_sel_i,
    input  bus_pkg::mem_req_t data_req_i,
    output logic              data_rvalid_o,
    output bus_pkg::mem_rsp_t data_rsp_o
);
    import bus_pkg::*;

    logic [tcm_awidth-3:0] instr_idx;
    logic [tcm_awidth-3:0] data_idx;
    be_t                   data_web;
    xlen_t                 ram_douta;
    xlen_t                 ram_doutb;

    // Fetch side never stalls
    assign instr_gnt_o = instr_req_i;

    // Word index, upper address bits dropped
    assign instr_idx = instr_addr_i[tcm_awidth-1:2];
    assign data_idx  = data_req_i.addr[tcm_awidth-1:2];
    assign data_web  = {$bits(be_t){data_req_i.we}} & data_req_i.be;   // Reads write nothing

    tcm_ram #(
        .tcm_awidth (tcm_awidth)
    ) tcm_ram_inst (
        .clk     (clk),
        .ena_i   (instr_req_i),   // Accepted fetch
        .enb_i   (data_sel_i),    // Select implies grant
        .addra_i (instr_idx),
        .addrb_i (data_idx),
        .web_i   (data_web),
        .dinb_i  (data_req_i.wdata),
        .douta_o (ram_douta),
        .doutb_o (ram_doutb)
    );

    // ------------------------------------------------------------------
    // Read-valid, one cycle after acceptance
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            instr_rvalid_o <= 1'b0;
            data_rvalid_o  <= 1'b0;
        end else begin
            instr_rvalid_o <= instr_req_i;
            data_rvalid_o  <= data_sel_i;
        end
    end

    // Data is zero outside its valid cycle
    assign instr_rdata_o    = instr_rvalid_o ? ram_douta : '0;
    assign data_rsp_o.rdata = data_rvalid_o ? ram_doutb : '0;
    assign data_rsp_o.err   = 1'b0;

endmodule

// ==== design/icb_bridge.sv ====
`timescale 1ns/100ps

module icb_bridge (
    input  logic              clk,
    input  logic              rst_n,
    // Core side, from the data mux
    input  logic              sel_i,
    input  bus_pkg::mem_req_t req_i,
    output logic              gnt_o,
    output logic              rvalid_o,
    output bus_pkg::mem_rsp_t rsp_o,
    // ICB command channel
    output logic              cmd_valid_o,
    input  logic              cmd_ready_i,
    output bus_pkg::icb_cmd_t cmd_o,
    // ICB response channel
    input  logic              rsp_valid_i,
    output logic              rsp_ready_o,
    input  bus_pkg::xlen_t    rsp_rdata_i
);
    import bus_pkg::*;

    logic  rsp_fire;
    xlen_t rdata_q;     // Captured response word

    // ------------------------------------------------------------------
    // Command path, combinational
    // ------------------------------------------------------------------
    assign cmd_valid_o = sel_i;                  // Follows routed request
    assign cmd_o.read  = ~req_i.we;
    assign cmd_o.addr  = req_i.addr;
    assign cmd_o.wdata = req_i.wdata;
    assign cmd_o.wmask = req_i.be;

    assign gnt_o = cmd_valid_o & cmd_ready_i;    // Grant on transfer

    // ------------------------------------------------------------------
    // Response path, one register stage
    // ------------------------------------------------------------------
    assign rsp_ready_o = 1'b1;                   // Always accept
    assign rsp_fire    = rsp_valid_i & rsp_ready_o;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rvalid_o <= 1'b0;
        end else begin
            rvalid_o <= rsp_fire;
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_fire) begin
            rdata_q <= rsp_rdata_i;
        end
    end

    assign rsp_o.rdata = rvalid_o ? rdata_q : '0;
    assign rsp_o.err   = 1'b0;                   // No bus errors here

endmodule

// ==== design/data_bus_mux.sv ====
`timescale 1ns/100ps

module data_bus_mux #(
    parameter int tcm_awidth = 12
) (
    input  logic              clk,
    input  logic              rst_n,
    // Core data bus
    input  logic              req_i,
    input  bus_pkg::mem_req_t req_bits_i,
    output logic              gnt_o,
    output logic              rvalid_o,
    output bus_pkg::mem_rsp_t rsp_o,
    // TCM target
    output logic              tcm_sel_o,
    input  logic              tcm_rvalid_i,
    input  bus_pkg::mem_rsp_t tcm_rsp_i,
    // Peripheral bridge
    output logic              icb_sel_o,
    input  logic              icb_gnt_i,
    input  logic              icb_rvalid_i,
    input  bus_pkg::mem_rsp_t icb_rsp_i
);
    import bus_pkg::*;
    import map_pkg::*;

    localparam int xlen = $bits(xlen_t);
    localparam int rsp_w = $bits(mem_rsp_t);

    // Offset bits inside the TCM window
    localparam xlen_t tcm_mask = {{(xlen - tcm_awidth){1'b0}}, {tcm_awidth{1'b1}}};

    region_e region;
    logic    icb_pending;   // Peripheral access granted, response not back yet

    // ------------------------------------------------------------------
    // Address decode
    // ------------------------------------------------------------------
    always_comb begin
        region = NONE;
        if ((req_bits_i.addr & ~tcm_mask) == (TCM_BASE & ~tcm_mask)) begin
            region = TCM;
        end else if ((req_bits_i.addr & ~PERIPH_MASK) == (PERIPH_BASE & ~PERIPH_MASK)) begin
            region = PERIPH;
        end
    end

    // One select at most, none while a peripheral access is open
    assign tcm_sel_o = req_i & ~icb_pending & (region == TCM);
    assign icb_sel_o = req_i & ~icb_pending & (region == PERIPH);

    // TCM takes it at once, bridge waits for ICB ready
    assign gnt_o = tcm_sel_o | (icb_sel_o & icb_gnt_i);

    // ------------------------------------------------------------------
    // Outstanding peripheral access
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            icb_pending <= 1'b0;
        end else if (icb_sel_o & icb_gnt_i) begin
            icb_pending <= 1'b1;        // Command went out
        end else if (icb_rvalid_i) begin
            icb_pending <= 1'b0;        // Response handed to core
        end
    end

    // ------------------------------------------------------------------
    // Response merge
    // ------------------------------------------------------------------
    // Valids never overlap, so a plain OR is enough
    assign rvalid_o = tcm_rvalid_i | icb_rvalid_i;
    assign rsp_o    = (tcm_rsp_i & {rsp_w{tcm_rvalid_i}}) |
                      (icb_rsp_i & {rsp_w{icb_rvalid_i}});

endmodule

// ==== design/coreplex_fabric.sv ====
`timescale 1ns/100ps

module coreplex_fabric #(
    parameter int tcm_awidth = 12                 // TCM size in byte address bits
) (
    input  logic              clk,
    input  logic              rst_n,
    // Core instruction bus
    input  logic              instr_req_i,
    input  bus_pkg::xlen_t    instr_addr_i,
    output logic              instr_gnt_o,
    output logic              instr_rvalid_o,
    output bus_pkg::xlen_t    instr_rdata_o,
    // Core data bus
    input  logic              data_req_i,
    input  bus_pkg::mem_req_t data_req_i_bits,
    output logic              data_gnt_o,
    output logic              data_rvalid_o,
    output bus_pkg::mem_rsp_t data_rsp_o,
    // Peripheral ICB
    output logic              icb_cmd_valid_o,
    input  logic              icb_cmd_ready_i,
    output bus_pkg::icb_cmd_t icb_cmd_o,
    input  logic              icb_rsp_valid_i,
    output logic              icb_rsp_ready_o,
    input  bus_pkg::xlen_t    icb_rsp_rdata_i
);
    import bus_pkg::*;

    logic     tcm_sel;
    logic     tcm_rvalid;
    mem_rsp_t tcm_rsp;
    logic     icb_sel;
    logic     icb_gnt;
    logic     icb_rvalid;
    mem_rsp_t icb_rsp;

    // ------------------------------------------------------------------
    // Data port decode and merge
    // ------------------------------------------------------------------
    data_bus_mux #(
        .tcm_awidth (tcm_awidth)
    ) data_bus_mux_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_i        (data_req_i),
        .req_bits_i   (data_req_i_bits),
        .gnt_o        (data_gnt_o),
        .rvalid_o     (data_rvalid_o),
        .rsp_o        (data_rsp_o),
        .tcm_sel_o    (tcm_sel),
        .tcm_rvalid_i (tcm_rvalid),
        .tcm_rsp_i    (tcm_rsp),
        .icb_sel_o    (icb_sel),
        .icb_gnt_i    (icb_gnt),
        .icb_rvalid_i (icb_rvalid),
        .icb_rsp_i    (icb_rsp)
    );

    // TCM, fetch on port A and data on port B
    tcm_port #(
        .tcm_awidth (tcm_awidth)
    ) tcm_port_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .instr_req_i    (instr_req_i),
        .instr_addr_i   (instr_addr_i),
        .instr_gnt_o    (instr_gnt_o),
        .instr_rvalid_o (instr_rvalid_o),
        .instr_rdata_o  (instr_rdata_o),
        .data_sel_i     (tcm_sel),
        .data_req_i     (data_req_i_bits),
        .data_rvalid_o  (tcm_rvalid),
        .data_rsp_o     (tcm_rsp)
    );

    // Peripheral region out to ICB
    icb_bridge icb_bridge_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .sel_i       (icb_sel),
        .req_i       (data_req_i_bits),
        .gnt_o       (icb_gnt),
        .rvalid_o    (icb_rvalid),
        .rsp_o       (icb_rsp),
        .cmd_valid_o (icb_cmd_valid_o),
        .cmd_ready_i (icb_cmd_ready_i),
        .cmd_o       (icb_cmd_o),
        .rsp_valid_i (icb_rsp_valid_i),
        .rsp_ready_o (icb_rsp_ready_o),
        .rsp_rdata_i (icb_rsp_rdata_i)
    );

endmodule

// ==== verif/coreplex_fabric_assert.sv ====
`timescale 1ns/100ps

module coreplex_fabric_assert (
    input logic              clk,
    input logic              rst_n,
    input logic              instr_req_i,
    input logic              instr_gnt_i,
    input logic              instr_rvalid_i,
    input logic              data_req_i,
    input logic              data_gnt_i,
    input logic              data_rvalid_i,
    input bus_pkg::mem_rsp_t data_rsp_i,
    input logic              icb_cmd_valid_i,
    input logic              icb_cmd_ready_i
);
    logic [2:0] data_open;          // Accepted data requests still owed an rvalid
    logic       icb_open;           // ICB command out, merged response not seen yet
    int         fail_instr = 0;
    int         fail_data  = 0;
    int         fail_icb   = 0;
    int         fail_rsp   = 0;
    int         fail_count;         // Tally of assertion failures

    assign fail_count = fail_instr + fail_data + fail_icb + fail_rsp;

    // ------------------------------------------------------------------
    // Shadow of the outstanding state
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            data_open <= '0;
            icb_open  <= 1'b0;
        end else begin
            data_open <= data_open + 3'(data_req_i & data_gnt_i) - 3'(data_rvalid_i);
            if (icb_cmd_valid_i & icb_cmd_ready_i) begin
                icb_open <= 1'b1;   // Set wins over a TCM rvalid in the same cycle
            end else if (data_rvalid_i) begin
                icb_open <= 1'b0;
            end
        end
    end

    // Fetch data only after an accepted fetch
    a_instr_rvalid: assert property (@(posedge clk) disable iff (!rst_n)
        instr_rvalid_i |-> $past(instr_req_i & instr_gnt_i))
        else begin
            fail_instr++;
            $error("instr_rvalid_o high without an accepted fetch one cycle before");
        end

    a_data_rvalid: assert property (@(posedge clk) disable iff (!rst_n)
        data_rvalid_i |-> (data_open != 3'd0))
        else begin
            fail_data++;
            $error("data_rvalid_o high with no accepted data request open");
        end

    // One peripheral access at a time
    a_icb_hold: assert property (@(posedge clk) disable iff (!rst_n)
        icb_open |-> !icb_cmd_valid_i)
        else begin
            fail_icb++;
            $error("icb_cmd_valid_o high while a peripheral response is pending");
        end

    a_rsp_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !data_rvalid_i |-> (data_rsp_i == '0))
        else begin
            fail_rsp++;
            $error("data_rsp_o not zero outside data_rvalid_o");
        end

endmodule

bind coreplex_fabric coreplex_fabric_assert coreplex_fabric_assert_inst (
    .clk             (clk),
    .rst_n           (rst_n),
    .instr_req_i     (instr_req_i),
    .instr_gnt_i     (instr_gnt_o),
    .instr_rvalid_i  (instr_rvalid_o),
    .data_req_i      (data_req_i),
    .data_gnt_i      (data_gnt_o),
    .data_rvalid_i   (data_rvalid_o),
    .data_rsp_i      (data_rsp_o),
    .icb_cmd_valid_i (icb_cmd_valid_o),
    .icb_cmd_ready_i (icb_cmd_ready_i)
);

// ==== verif/tb_coreplex_fabric.sv ====
`timescale 1ns/100ps

module tb_coreplex_fabric;
    import bus_pkg::*;
    import map_pkg::*;

    localparam int tcm_awidth     = 12;
    localparam int tcm_depth      = 2 ** (tcm_awidth - 2);
    localparam int n_trans        = 400;
    localparam int timeout_cycles = n_trans * 12;

    // DUT ports
    logic     clk = 1'b0;
    logic     rst_n;
    logic     instr_req_i;
    xlen_t    instr_addr_i;
    logic     instr_gnt_o;
    logic     instr_rvalid_o;
    xlen_t    instr_rdata_o;
    logic     data_req_i;
    mem_req_t data_req_i_bits;
    logic     data_gnt_o;
    logic     data_rvalid_o;
    mem_rsp_t data_rsp_o;
    logic     icb_cmd_valid_o;
    logic     icb_cmd_ready_i;
    icb_cmd_t icb_cmd_o;
    logic     icb_rsp_valid_i;
    logic     icb_rsp_ready_o;
    xlen_t    icb_rsp_rdata_i;

    // Model state
    xlen_t    shadow [tcm_depth];   // Expected TCM contents
    xlen_t    rsp_q [$];            // Slave read data in arrival order
    xlen_t    rng;
    int       issued;
    int       errors;
    int       checks;
    int       cycles = 0;
    int       slave_delay;
    logic     instr_exp_v;          // Fetch rvalid due this cycle
    xlen_t    instr_exp_d;
    logic     data_exp_v;           // Data rvalid due this cycle
    logic     data_exp_rd;
    logic     data_exp_icb;
    xlen_t    data_exp_d;
    logic     icb_pending;
    logic     icb_is_rd;
    logic     icb_done;
    logic     slave_wait;
    logic     exp_gnt;
    logic     exp_cmd_v;
    logic     instr_fire;
    logic     data_fire;
    logic     finished;
    region_e  region;
    mem_req_t req;
    logic [tcm_awidth-3:0] idx;

    coreplex_fabric #(
        .tcm_awidth (tcm_awidth)
    ) coreplex_fabric_inst (.*);

    always #20 clk = ~clk;

    function automatic xlen_t xorshift(input xlen_t s);
        xlen_t x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Region from the address map
    function automatic region_e region_of(input xlen_t addr);
        xlen_t tcm_off;
        tcm_off = (32'd1 << tcm_awidth) - 32'd1;
        if ((addr & ~tcm_off) == TCM_BASE) begin
            return TCM;
        end
        if ((addr & ~PERIPH_MASK) == PERIPH_BASE) begin
            return PERIPH;
        end
        return NONE;
    endfunction

    task automatic check_value(input string name, input xlen_t exp, input xlen_t act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    initial begin
        rng          = 32'd66912;
        issued       = 0;
        errors       = 0;
        checks       = 0;
        instr_exp_v  = 1'b0;
        data_exp_v   = 1'b0;
        data_exp_rd  = 1'b0;
        data_exp_icb = 1'b0;
        icb_pending  = 1'b0;
        icb_is_rd    = 1'b0;
        slave_wait   = 1'b0;
        slave_delay  = 0;
        finished     = 1'b0;
        for (int i = 0; i < tcm_depth; i++) begin
            shadow[i] = '0;
        end
        rst_n           <= 1'b0;
        instr_req_i     <= 1'b0;
        instr_addr_i    <= '0;
        data_req_i      <= 1'b0;
        data_req_i_bits <= '0;
        icb_cmd_ready_i <= 1'b0;
        icb_rsp_valid_i <= 1'b0;
        icb_rsp_rdata_i <= '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        while (!finished) begin
            @(posedge clk);
            // ------------------------------------------------------------------
            // Responses of the cycle that just ended
            // ------------------------------------------------------------------
            check_value("instr_rvalid", 32'(instr_exp_v), 32'(instr_rvalid_o));
            if (instr_exp_v) begin
                check_value("instr_rdata", instr_exp_d, instr_rdata_o);
            end
            check_value("data_rvalid", 32'(data_exp_v), 32'(data_rvalid_o));
            if (data_exp_v && data_exp_rd) begin
                check_value("data_rdata", data_exp_d, data_rsp_o.rdata);
            end else if (!data_exp_v) begin
                check_value("data_rdata_idle", '0, data_rsp_o.rdata);
            end
            check_value("data_err", '0, 32'(data_rsp_o.err));
            check_value("icb_rsp_ready", 32'd1, 32'(icb_rsp_ready_o));
            icb_done   = data_exp_v & data_exp_icb;    // Pending drops after this cycle
            data_exp_v = 1'b0;
            finished   = (issued == n_trans) && !instr_req_i && !data_req_i &&
                         !icb_rsp_valid_i && !icb_pending && !slave_wait;

            // ------------------------------------------------------------------
            // Requests of the cycle that just ended
            // ------------------------------------------------------------------
            instr_fire  = instr_req_i & instr_gnt_o;
            check_value("instr_gnt", 32'(instr_req_i), 32'(instr_gnt_o));
            instr_exp_v = instr_fire;
            instr_exp_d = shadow[instr_addr_i[tcm_awidth-1:2]];   // Before this edge's write

            region    = region_of(data_req_i_bits.addr);
            exp_cmd_v = data_req_i & !icb_pending & (region == PERIPH);
            exp_gnt   = data_req_i & !icb_pending &
                        ((region == TCM) | (exp_cmd_v & icb_cmd_ready_i));
            check_value("data_gnt", 32'(exp_gnt), 32'(data_gnt_o));
            check_value("icb_cmd_valid", 32'(exp_cmd_v), 32'(icb_cmd_valid_o));
            if (exp_cmd_v) begin
                check_value("icb_cmd_addr", data_req_i_bits.addr, icb_cmd_o.addr);
                check_value("icb_cmd_read", 32'(!data_req_i_bits.we), 32'(icb_cmd_o.read));
                check_value("icb_cmd_wdata", data_req_i_bits.wdata, icb_cmd_o.wdata);
                check_value("icb_cmd_wmask", 32'(data_req_i_bits.be), 32'(icb_cmd_o.wmask));
            end

            data_fire = exp_gnt;
            idx       = data_req_i_bits.addr[tcm_awidth-1:2];
            if (data_fire && region == TCM) begin
                data_exp_v   = 1'b1;
                data_exp_icb = 1'b0;
                data_exp_rd  = !data_req_i_bits.we;
                data_exp_d   = shadow[idx];
                if (data_req_i_bits.we) begin
                    for (int i = 0; i < 4; i++) begin
                        if (data_req_i_bits.be[i]) begin
                            shadow[idx][i*8 +: 8] = data_req_i_bits.wdata[i*8 +: 8];
                        end
                    end
                end
            end
            if (data_fire && region == PERIPH) begin
                icb_pending = 1'b1;
                icb_is_rd   = !data_req_i_bits.we;
                slave_wait  = 1'b1;
                rng         = xorshift(rng);
                slave_delay = int'(rng % 7);    // 0 to 6 cycles
            end
            if (icb_rsp_valid_i) begin
                data_exp_v   = 1'b1;            // Registered in the bridge
                data_exp_icb = 1'b1;
                data_exp_rd  = icb_is_rd;
                data_exp_d   = rsp_q.pop_front();
            end
            if (icb_done) begin
                icb_pending = 1'b0;
            end

            // ------------------------------------------------------------------
            // ICB slave drive
            // ------------------------------------------------------------------
            icb_rsp_valid_i <= 1'b0;
            if (slave_wait) begin
                if (slave_delay == 0) begin
                    rng             = xorshift(rng);
                    slave_wait      = 1'b0;
                    icb_rsp_valid_i <= 1'b1;
                    icb_rsp_rdata_i <= rng;
                    rsp_q.push_back(rng);
                end else begin
                    slave_delay--;
                end
            end
            rng = xorshift(rng);
            icb_cmd_ready_i <= rng[0] | rng[1];     // Ready about 3 cycles in 4

            // ------------------------------------------------------------------
            // Core drive
            // ------------------------------------------------------------------
            // Fetch is granted at once and may restart every cycle
            rng = xorshift(rng);
            instr_req_i <= 1'b0;
            if (issued < n_trans && rng[0]) begin
                instr_req_i  <= 1'b1;
                instr_addr_i <= TCM_BASE | 32'({rng[8:4], 2'b00});
                issued++;
            end

            if (data_fire || !data_req_i) begin
                rng = xorshift(rng);
                data_req_i <= 1'b0;
                if (issued < n_trans && rng[0]) begin
                    req.we   = rng[1];
                    req.be   = rng[1] ? rng[7:4] : 4'hf;
                    req.addr = rng[2] ? (PERIPH_BASE | (rng & PERIPH_MASK & 32'hffff_fffc))
                                      : (TCM_BASE | 32'({rng[12:8], 2'b00}));
                    rng       = xorshift(rng);
                    req.wdata = rng;
                    data_req_i      <= 1'b1;
                    data_req_i_bits <= req;         // Held until granted
                    issued++;
                end
            end
        end

        errors += coreplex_fabric_inst.coreplex_fabric_assert_inst.fail_count;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // Run length guard
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("Timeout: transactions still open after %0d cycles", cycles);
            $display("Checks: %0d, errors: %0d", checks, errors);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

endmodule

// ==== tb.f ====
design/bus_pkg.sv
design/map_pkg.sv
design/tcm_ram.sv
design/tcm_port.sv
design/icb_bridge.sv
design/data_bus_mux.sv
design/coreplex_fabric.sv
verif/coreplex_fabric_assert.sv
verif/tb_coreplex_fabric.sv

// ==== Makefile ====
TOP := tb_coreplex_fabric
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only design/bus_pkg.sv design/map_pkg.sv design/tcm_ram.sv \
		design/tcm_port.sv design/icb_bridge.sv design/data_bus_mux.sv \
		design/coreplex_fabric.sv --top-module coreplex_fabric
	verilator --lint-only --timing -f tb.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^TEST RESULT: PASS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
